// ==== ldq.f ====
source/ldqPkg.sv
source/ldqIfs.sv
source/ldqEntry.sv
source/ldqArray.sv
source/ldqCheckStage.sv
source/ldqRetireCtrl.sv
source/ldqTop.sv
bench/ldqClockGen.sv
bench/ldqMonitor.sv
bench/ldqBench.sv

// ==== Bender.yml ====
package:
  name: ldq

sources:
  - files:
      - source/ldqPkg.sv
      - source/ldqIfs.sv
      - source/ldqEntry.sv
      - source/ldqArray.sv
      - source/ldqCheckStage.sv
      - source/ldqRetireCtrl.sv
      - source/ldqTop.sv
  - target: test
    files:
      - bench/ldqClockGen.sv
      - bench/ldqMonitor.sv
      - bench/ldqBench.sv

// ==== bench/ldqBench.sv ====
`timescale 1ns/1ps

module ldqBench;
  import ldqPkg::*;

  localparam int HALF_PERIOD = 4;
  localparam int RESET_CYCLES = 8;
  localparam int RESET_TIMEOUT = 40;
  localparam int HS_TIMEOUT = 20;
  localparam int LOOKUP_DELAY = 2;
  localparam int RANDOM_OPS = 300;
  localparam lineAddrT RANDOM_BASE = 16'h3a40;
  localparam logic [31:0] SEED = 32'h888f8ad4;

  logic clk, rst, newEn, chkEn, retireReq, full, retireAck, retireHit, retireConfl;
  lineAddrT newAddr, chkAddr;
  bankMaskT newBanks, chkBanks;
  loadIdT newId, retireId, lastRetired;
  logic fullChk, expFull, expHit, expConfl;
  logic [127:0] curTest;
  logic [31:0] lfsr;
  int monErrors;
  int benchErrors;
  int cycleNo;
  int waitCount;
  int pick;
  logic mixChecks;
  lineAddrT addr;
  bankMaskT banks;

  // model of the held loads and of every check seen
  logic heldValid [ENTRY_COUNT];
  lineAddrT heldAddr [ENTRY_COUNT];
  bankMaskT heldBanks [ENTRY_COUNT];
  loadIdT heldId [ENTRY_COUNT];
  int heldCycle [ENTRY_COUNT];
  int chkCycleQ[$];
  lineAddrT chkAddrQ[$];
  bankMaskT chkBanksQ[$];

  ldqClockGen #(.HALF_PERIOD(HALF_PERIOD), .RESET_CYCLES(RESET_CYCLES)) i_ldqClockGen (
    .clk(clk),
    .rst(rst)
  );

  ldqTop i_ldqTop (.*);

  ldqMonitor #(.ACK_RISE(LOOKUP_DELAY), .ACK_FALL(1), .NAME_BITS(128)) i_ldqMonitor (
    .clk(clk), .rst(rst), .full(full), .retireReq(retireReq), .retireAck(retireAck),
    .retireHit(retireHit), .retireConfl(retireConfl), .fullChk(fullChk), .expFull(expFull),
    .expHit(expHit), .expConfl(expConfl), .testName(curTest), .errorCount(monErrors)
  );

  always @(posedge clk) cycleNo <= cycleNo + 1;

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] takeBits(input int n);
    logic [31:0] bits;
    logic fb;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      bits = {bits[30:0], fb};
    end
    return bits;
  endfunction

  function automatic int findSlot(input loadIdT id);
    for (int s = 0; s < ENTRY_COUNT; s++) begin
      if (heldValid[s] && heldId[s] == id) return s;
    end
    return -1;
  endfunction

  function automatic int heldCount();
    int n;
    n = 0;
    for (int s = 0; s < ENTRY_COUNT; s++) n += heldValid[s];
    return n;
  endfunction

  // expected {hit, confl} for a lookup in cycle lookCycle
  function automatic logic [1:0] refRetire(input loadIdT id, input int lookCycle);
    int s;
    logic confl;
    s = findSlot(id);
    confl = 1'b0;
    if (s < 0 || heldCycle[s] >= lookCycle) return 2'b00;
    // a check in cycle c covers loads allocated up to c+1
    foreach (chkCycleQ[k]) begin
      if (chkCycleQ[k] + 1 >= heldCycle[s] && chkCycleQ[k] < lookCycle &&
          chkAddrQ[k] == heldAddr[s] && (chkBanksQ[k] & heldBanks[s]) != '0) begin
        confl = 1'b1;
      end
    end
    return {1'b1, confl};
  endfunction

  function automatic loadIdT freshId();
    loadIdT id;
    id = loadIdT'(takeBits(ID_WIDTH));
    while (findSlot(id) >= 0) id++;
    return id;
  endfunction

  // mostly a held id and sometimes the last retired one
  function automatic loadIdT pickId();
    int start;
    start = int'(takeBits($clog2(ENTRY_COUNT)));
    for (int k = 1; k <= ENTRY_COUNT && start != 0; k++) begin
      if (heldValid[(start + k) % ENTRY_COUNT]) return heldId[(start + k) % ENTRY_COUNT];
    end
    return lastRetired;
  endfunction

  task automatic timeoutError(input string what);
    benchErrors++;
    $display("timeout in test %0s: %0s", curTest, what);
  endtask

  task automatic tick();
    @(negedge clk);
    newEn <= 1'b0;
    chkEn <= 1'b0;
    fullChk <= 1'b0;
  endtask

  task automatic allocLoad(input lineAddrT a, input bankMaskT b, input loadIdT id);
    int s;
    tick();
    s = 0;
    while (heldValid[s]) s++;
    heldValid[s] = 1'b1;
    heldAddr[s] = a;
    heldBanks[s] = b;
    heldId[s] = id;
    heldCycle[s] = cycleNo;
    newEn <= 1'b1;
    newAddr <= a;
    newBanks <= b;
    newId <= id;
    fullChk <= 1'b1;
    expFull <= (heldCount() == ENTRY_COUNT);
  endtask

  task automatic driveCheck(input lineAddrT a, input bankMaskT b);
    chkEn <= 1'b1;
    chkAddr <= a;
    chkBanks <= b;
    chkCycleQ.push_back(cycleNo);
    chkAddrQ.push_back(a);
    chkBanksQ.push_back(b);
  endtask

  task automatic checkStore(input lineAddrT a, input bankMaskT b);
    tick();
    driveCheck(a, b);
  endtask

  task automatic retireLoad(input loadIdT id);
    logic [1:0] want;
    int waited;
    tick();
    retireReq <= 1'b1;
    retireId <= id;
    waited = 0;
    while (!retireAck && waited < HS_TIMEOUT) begin
      tick();
      waited++;
      // stores racing the lookup
      if (mixChecks && waited <= LOOKUP_DELAY && takeBits(1) != 0) begin
        driveCheck(addr, banks);
      end
      // the lookup runs now and frees the entry at the end of this cycle
      if (waited == LOOKUP_DELAY) begin
        want = refRetire(id, cycleNo);
        expHit <= want[1];
        expConfl <= want[0];
        if (want[1]) begin
          heldValid[findSlot(id)] = 1'b0;
          lastRetired = id;
        end
        fullChk <= 1'b1;
        expFull <= (heldCount() == ENTRY_COUNT);
      end
    end
    if (!retireAck) timeoutError("retireAck never rose");
    tick();
    retireReq <= 1'b0;
    waited = 0;
    while (retireAck && waited < HS_TIMEOUT) begin
      tick();
      waited++;
    end
    if (retireAck) timeoutError("retireAck never fell");
  endtask

  initial begin
    lfsr = SEED;
    newEn = 1'b0;
    newAddr = '0;
    newBanks = '0;
    newId = '0;
    chkEn = 1'b0;
    chkAddr = '0;
    chkBanks = '0;
    retireReq = 1'b0;
    retireId = '0;
    fullChk = 1'b0;
    expFull = 1'b0;
    expHit = 1'b0;
    expConfl = 1'b0;
    lastRetired = '0;
    mixChecks = 1'b0;
    benchErrors = 0;
    foreach (heldValid[s]) heldValid[s] = 1'b0;
    curTest = "reset";
    for (waitCount = 0; waitCount < RESET_TIMEOUT && rst !== 1'b0; waitCount++) begin
      @(negedge clk);
    end
    if (rst !== 1'b0) timeoutError("reset never released");
    retireLoad(6'h2a);

    curTest <= "fillDrain";
    for (int i = 0; i < ENTRY_COUNT; i++) begin
      allocLoad(lineAddrT'(16'h1000 + i), bankMaskT'(1) << i, loadIdT'(i + 1));
    end
    for (int i = 0; i < ENTRY_COUNT; i++) retireLoad(loadIdT'(i + 1));

    curTest <= "match";
    allocLoad(16'h2200, 16'h00f0, 6'd10);
    checkStore(16'h2200, 16'h0010);
    retireLoad(6'd10);

    curTest <= "noMatch";
    allocLoad(16'h2300, 16'h000f, 6'd11);
    allocLoad(16'h2400, 16'h0f00, 6'd12);
    checkStore(16'h2301, 16'h000f);
    checkStore(16'h2400, 16'hf000);
    retireLoad(6'd11);
    retireLoad(6'd12);

    // check one cycle ahead of the load and then two ahead
    curTest <= "sameCycle";
    checkStore(16'h2500, 16'h0003);
    allocLoad(16'h2500, 16'h0001, 6'd13);
    checkStore(16'h2600, 16'h0003);
    tick();
    allocLoad(16'h2600, 16'h0002, 6'd14);
    retireLoad(6'd13);
    retireLoad(6'd14);

    curTest <= "random";
    mixChecks = 1'b1;
    for (int op = 0; op < RANDOM_OPS; op++) begin
      pick = int'(takeBits(3));
      addr = RANDOM_BASE | lineAddrT'(takeBits(2));
      banks = bankMaskT'(1) << takeBits($clog2(BANK_COUNT));
      banks |= bankMaskT'(1) << takeBits($clog2(BANK_COUNT));
      if (pick < 3 && heldCount() < ENTRY_COUNT) allocLoad(addr, banks, freshId());
      else if (pick < 5) checkStore(addr, banks);
      else if (pick < 7) retireLoad(pickId());
      else tick();
    end
    retireLoad(pickId());
    retireLoad(lastRetired);

    tick();
    tick();
    $display("value errors: %0d, protocol errors: %0d", monErrors, benchErrors);
    if (monErrors == 0 && benchErrors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// ==== bench/ldqMonitor.sv ====
`timescale 1ns/1ps

module ldqMonitor #(
  parameter int ACK_RISE = 2,
  parameter int ACK_FALL = 1,
  parameter int NAME_BITS = 128
) (
  input logic clk,
  input logic rst,
  input logic full,
  input logic retireReq,
  input logic retireAck,
  input logic retireHit,
  input logic retireConfl,
  input logic fullChk,
  input logic expFull,
  input logic expHit,
  input logic expConfl,
  input logic [NAME_BITS-1:0] testName,
  output int errorCount
);

  logic reqSeen;
  logic ackSeen;
  logic resetChecked;
  int sinceRise;
  int sinceFall;

  task automatic mismatch(input logic [NAME_BITS-1:0] name, input string what,
                          input logic [31:0] want, input logic [31:0] got);
    errorCount++;
    $display("ERROR %0s: %0s expected %0d, actual %0d", name, what, want, got);
  endtask

  initial errorCount = 0;

  // falling edge, DUT outputs and bench expectations are settled here
  always @(negedge clk) begin
    if (rst) begin
      reqSeen = 1'b0;
      ackSeen = 1'b0;
      resetChecked = 1'b0;
      sinceRise = 0;
      sinceFall = 0;
    end else begin
      if (!resetChecked) begin
        if (full !== 1'b0) mismatch("reset", "full", 0, full);
        if (retireAck !== 1'b0) mismatch("reset", "retireAck", 0, retireAck);
        resetChecked = 1'b1;
      end
      sinceRise = (retireReq && !reqSeen) ? 0 : sinceRise + 1;
      sinceFall = (!retireReq && reqSeen) ? 0 : sinceFall + 1;
      if (fullChk && full !== expFull) mismatch(testName, "full", expFull, full);
      if (retireAck && !ackSeen) begin
        if (sinceRise != ACK_RISE) mismatch(testName, "cycles to ack rise", ACK_RISE, sinceRise);
        if (retireHit !== expHit) mismatch(testName, "retireHit", expHit, retireHit);
        if (retireConfl !== expConfl) mismatch(testName, "retireConfl", expConfl, retireConfl);
      end
      if (!retireAck && ackSeen && sinceFall != ACK_FALL) begin
        mismatch(testName, "cycles to ack fall", ACK_FALL, sinceFall);
      end
      reqSeen = retireReq;
      ackSeen = retireAck;
    end
  end

endmodule

// ==== bench/ldqClockGen.sv ====
`timescale 1ns/1ps

module ldqClockGen #(
  parameter int HALF_PERIOD = 4,
  parameter int RESET_CYCLES = 8
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // release on a falling edge, away from the sampling edge
  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst <= 1'b0;
  end

endmodule

// ==== source/ldqTop.sv ====
`timescale 1ns/1ps

module ldqTop (
  input logic clk,
  input logic rst,
  input logic newEn,
  input ldqPkg::lineAddrT newAddr,
  input ldqPkg::bankMaskT newBanks,
  input ldqPkg::loadIdT newId,
  output logic full,
  input logic chkEn,
  input ldqPkg::lineAddrT chkAddr,
  input ldqPkg::bankMaskT chkBanks,
  input logic retireReq,
  input ldqPkg::loadIdT retireId,
  output logic retireAck,
  output logic retireHit,
  output logic retireConfl
);
  import ldqPkg::*;

  logic regEn;
  lineAddrT regAddr;
  bankMaskT regBanks;

  ldqAllocIf allocBus ();
  ldqRetireIf retireBus ();

  assign allocBus.en = newEn;
  assign allocBus.addr = newAddr;
  assign allocBus.banks = newBanks;
  assign allocBus.id = newId;

  ldqCheckStage i_ldqCheckStage (
    .clk(clk),
    .rst(rst),
    .chkEn(chkEn),
    .chkAddr(chkAddr),
    .chkBanks(chkBanks),
    .regEn(regEn),
    .regAddr(regAddr),
    .regBanks(regBanks)
  );

  ldqArray i_ldqArray (
    .clk(clk),
    .rst(rst),
    .alloc(allocBus.receiver),
    .retire(retireBus.array),
    .regEn(regEn),
    .regAddr(regAddr),
    .regBanks(regBanks),
    .full(full)
  );

  ldqRetireCtrl i_ldqRetireCtrl (
    .clk(clk),
    .rst(rst),
    .retireReq(retireReq),
    .retireId(retireId),
    .retire(retireBus.ctrl),
    .retireAck(retireAck),
    .retireHit(retireHit),
    .retireConfl(retireConfl)
  );

endmodule

// ==== source/ldqRetireCtrl.sv ====
`timescale 1ns/1ps

module ldqRetireCtrl (
  input logic clk,
  input logic rst,
  input logic retireReq,
  input ldqPkg::loadIdT retireId,
  ldqRetireIf.ctrl retire,
  output logic retireAck,
  output logic retireHit,
  output logic retireConfl
);
  import ldqPkg::*;

  typedef enum logic [1:0] {
    Idle,
    Lookup,
    Acked,
    Drop
  } stateT;

  stateT state;
  stateT stateNext;
  logic reqReg;
  loadIdT idReg;
  logic hitReg;
  logic conflReg;

  always_ff @(posedge clk) begin
    if (rst) begin
      reqReg <= 1'b0;
    end else begin
      reqReg <= retireReq;
    end
  end

  always_ff @(posedge clk) begin
    if (retireReq) begin
      idReg <= retireId;
    end
  end

  always_comb begin
    stateNext = state;
    case (state)
      Idle: if (reqReg) stateNext = Lookup;
      Lookup: stateNext = Acked;
      Acked: if (!reqReg) stateNext = Drop;
      default: stateNext = Idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= Idle;
    end else begin
      state <= stateNext;
    end
  end

  // result held for the whole ack phase
  always_ff @(posedge clk) begin
    if (state == Lookup) begin
      hitReg <= retire.hit;
      conflReg <= retire.confl;
    end
  end

  assign retire.lookup = (state == Lookup);
  assign retire.id = idReg;

  assign retireAck = (state == Acked);
  assign retireHit = hitReg;
  assign retireConfl = conflReg;

  // id must not move during a request
  reqIdStable: assert property (
    @(posedge clk) disable iff (rst)
    retireReq && $past(retireReq) |-> retireId == $past(retireId)
  ) else $error("retireId changed while retireReq high");

endmodule

// ==== source/ldqCheckStage.sv ====
`timescale 1ns/1ps

module ldqCheckStage (
  input logic clk,
  input logic rst,
  input logic chkEn,
  input ldqPkg::lineAddrT chkAddr,
  input ldqPkg::bankMaskT chkBanks,
  output logic regEn,
  output ldqPkg::lineAddrT regAddr,
  output ldqPkg::bankMaskT regBanks
);

  always_ff @(posedge clk) begin
    if (rst) begin
      regEn <= 1'b0;
    end else begin
      regEn <= chkEn;
    end
  end

  // address and banks only matter with regEn set
  always_ff @(posedge clk) begin
    if (chkEn) begin
      regAddr <= chkAddr;
      regBanks <= chkBanks;
    end
  end

endmodule

// ==== source/ldqArray.sv ====
`timescale 1ns/1ps

module ldqArray (
  input logic clk,
  input logic rst,
  ldqAllocIf.receiver alloc,
  ldqRetireIf.array retire,
  input logic regEn,
  input ldqPkg::lineAddrT regAddr,
  input ldqPkg::bankMaskT regBanks,
  output logic full
);
  import ldqPkg::*;

  entryVecT freeVec;
  entryVecT selVec;
  entryVecT hitVec;
  entryVecT conflVec;
  entryVecT releaseVec;

  // lowest free entry takes the new load
  assign selVec = freeVec & (~freeVec + entryVecT'(1));

  // only the entry holding the id gets freed
  assign releaseVec = hitVec & {ENTRY_COUNT{retire.lookup}};

  for (genvar i = 0; i < ENTRY_COUNT; i++) begin : genEntry
    ldqEntry i_ldqEntry (
      .clk(clk),
      .rst(rst),
      .alloc(alloc),
      .sel(selVec[i]),
      .regEn(regEn),
      .regAddr(regAddr),
      .regBanks(regBanks),
      .lookId(retire.id),
      .releaseEn(releaseVec[i]),
      .isFree(freeVec[i]),
      .idHit(hitVec[i]),
      .confl(conflVec[i])
    );
  end

  assign full = ~|freeVec;

  assign retire.hit = |hitVec;
  assign retire.confl = |conflVec;

  // sender must hold off while the queue is full
  allocWhileFull: assert property (
    @(posedge clk) disable iff (rst)
    alloc.en |-> !full
  ) else $error("load allocated while queue full");

  // ids are unique among held loads
  singleIdHit: assert property (
    @(posedge clk) disable iff (rst)
    retire.lookup |-> $onehot0(hitVec)
  ) else $error("retire id found in more than one entry");

endmodule

// ==== source/ldqEntry.sv ====
`timescale 1ns/1ps

module ldqEntry (
  input logic clk,
  input logic rst,
  ldqAllocIf.receiver alloc,
  input logic sel,
  input logic regEn,
  input ldqPkg::lineAddrT regAddr,
  input ldqPkg::bankMaskT regBanks,
  input ldqPkg::loadIdT lookId,
  input logic releaseEn,
  output logic isFree,
  output logic idHit,
  output logic confl
);
  import ldqPkg::*;

  logic valid;
  logic conflFlag;
  lineAddrT addr;
  bankMaskT banks;
  loadIdT id;
  logic write;
  logic newMatch;
  logic heldMatch;

  assign write = alloc.en && sel;

  // load arriving now vs. the registered check
  assign newMatch = regEn && (alloc.addr == regAddr) && (|(alloc.banks & regBanks));

  // held load vs. the registered check
  assign heldMatch = valid && regEn && (addr == regAddr) && (|(banks & regBanks));

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= 1'b0;
      conflFlag <= 1'b0;
    end else if (write) begin
      valid <= 1'b1;
      conflFlag <= newMatch;
    end else if (releaseEn) begin
      valid <= 1'b0;
      conflFlag <= 1'b0;
    end else if (heldMatch) begin
      conflFlag <= 1'b1;
    end
  end

  // payload
  always_ff @(posedge clk) begin
    if (write) begin
      addr <= alloc.addr;
      banks <= alloc.banks;
      id <= alloc.id;
    end
  end

  assign isFree = ~valid;
  assign idHit = valid && (id == lookId);

  // a check landing in the lookup cycle counts too,
  // otherwise it would be lost when the entry is freed
  assign confl = idHit && (conflFlag || heldMatch);

endmodule

// ==== source/ldqIfs.sv ====
`timescale 1ns/1ps

// new load, single-cycle strobe
interface ldqAllocIf;
  import ldqPkg::*;

  logic en;
  lineAddrT addr;
  bankMaskT banks;
  loadIdT id;

  modport receiver (
    input en,
    input addr,
    input banks,
    input id
  );
endinterface

// retire lookup, hit and confl answer in the same cycle
interface ldqRetireIf;
  import ldqPkg::*;

  logic lookup;
  loadIdT id;
  logic hit;
  logic confl;

  modport ctrl (
    output lookup,
    output id,
    input hit,
    input confl
  );

  modport array (
    input lookup,
    input id,
    output hit,
    output confl
  );
endinterface

// ==== source/ldqPkg.sv ====
package ldqPkg;

  // queue geometry
  localparam int ENTRY_COUNT = 8;
  localparam int LINE_WIDTH = 16;
  localparam int BANK_COUNT = 16;
  localparam int ID_WIDTH = 6;

  // cache-line address, no offset bits
  typedef logic [LINE_WIDTH-1:0] lineAddrT;

  // one bit per bank inside the line
  typedef logic [BANK_COUNT-1:0] bankMaskT;

  // instruction id of a load
  typedef logic [ID_WIDTH-1:0] loadIdT;

  // per-entry vector, bit i is entry i
  typedef logic [ENTRY_COUNT-1:0] entryVecT;

endpackage
